// ==== design/snes_bus_pkg.sv ====
`default_nettype none

package snes_bus_pkg;

  ////////////////////////////////
  // Console address bus
  ////////////////////////////////

  // Full 24-bit CPU address (bank:offset)
  typedef logic [23:0] snes_addr_t;

  ////////////////////////////////
  // Synced bus levels
  ////////////////////////////////

  // Filtered copies of the console control lines
  typedef struct packed {
    logic       read_n;    // Active low read strobe
    logic       cpu_clk;   // CPU clock level
    logic       romsel_n;  // Active low ROM select
    snes_addr_t addr;      // Address, delayed to settle
  } snes_levels_t;

  ////////////////////////////////
  // Single-cycle event pulses
  ////////////////////////////////

  // One CLK2 cycle wide each
  typedef struct packed {
    logic cycle_start;  // CPU clock rising
    logic cycle_end;    // CPU clock falling
    logic rd_start;     // Read strobe falling
  } snes_strobes_t;

endpackage

`default_nettype wire

// ==== design/rom_bus_pkg.sv ====
`default_nettype none

package rom_bus_pkg;

  ////////////////////////////////
  // ROM addressing and data
  ////////////////////////////////

  // Byte address into the ROM image, bit 0 picks the lane
  typedef logic [23:0] rom_addr_t;

  // PSRAM data word, used whole or split into lanes
  typedef union packed {
    logic [15:0] word;
    struct packed {
      logic [7:0] hi;  // Even byte
      logic [7:0] lo;  // Odd byte
    } bytes;
  } rom_word_u;

  ////////////////////////////////
  // MCU side
  ////////////////////////////////

  typedef struct packed {
    logic       rrq;    // Read request pulse
    logic       wrq;    // Write request pulse
    rom_addr_t  addr;
    logic [7:0] wdata;
  } mcu_req_t;

  // FSM states in which the MCU drives the ROM port
  typedef struct packed {
    logic rd_hit;
    logic wr_hit;
  } mcu_grant_t;

  ////////////////////////////////
  // PSRAM pins
  ////////////////////////////////

  typedef struct packed {
    logic [22:0] addr;     // Word address
    logic        we_n;
    logic        bhe_n;    // High byte enable, active low
    logic        ble_n;    // Low byte enable, active low
    logic        data_oe;  // Drive rom_data_out onto the bus
  } rom_ctrl_t;

endpackage

`default_nettype wire

// ==== design/snes_bus_sync.sv ====
`default_nettype none

module snes_bus_sync
  import snes_bus_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n,
  input  snes_addr_t    snes_addr,
  input  logic          snes_read_n,
  input  logic          snes_cpu_clk,
  input  logic          snes_romsel_n,
  output snes_levels_t  levels,
  output snes_strobes_t strobes
);

  // Sample histories, newest sample in bit 0
  logic [6:0] read_hist;
  logic [6:0] clk_hist;
  logic [6:0] romsel_hist;

  snes_addr_t addr_hist [7];  // Address pipeline

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      read_hist   <= '1;  // Bus idle
      clk_hist    <= '0;
      romsel_hist <= '1;
    end else begin
      read_hist   <= {read_hist[5:0], snes_read_n};
      clk_hist    <= {clk_hist[5:0], snes_cpu_clk};
      romsel_hist <= {romsel_hist[5:0], snes_romsel_n};
    end
  end

  always_ff @(posedge clk) begin
    addr_hist[0] <= snes_addr;
    for (int i = 1; i < 7; i++) begin
      addr_hist[i] <= addr_hist[i-1];
    end
  end

  ////////////////////////////////
  // Levels
  ////////////////////////////////

  // Two adjacent stages must agree on a high, so single-sample glitches drop out
  assign levels.read_n   = read_hist[2] & read_hist[1];
  assign levels.cpu_clk  = clk_hist[2] & clk_hist[1];
  assign levels.romsel_n = romsel_hist[2] & romsel_hist[1];
  assign levels.addr     = addr_hist[6] & addr_hist[5];  // Late tap, lets the bus settle

  ////////////////////////////////
  // Edge strobes
  ////////////////////////////////

  // Five stable samples, then the new level
  assign strobes.cycle_start = (clk_hist[6:1] == 6'b000001);
  assign strobes.cycle_end   = (clk_hist[6:1] == 6'b111110);
  assign strobes.rd_start    = (read_hist[6:1] == 6'b111110);

  // Stage 0 only feeds the shift chain

endmodule

`default_nettype wire

// ==== design/snes_alive_timer.sv ====
`default_nettype none

module snes_alive_timer
  import snes_bus_pkg::*;
#(
  parameter int unsigned DEAD_TIMEOUT = 96000  // About 1 ms of CLK2
) (
  input  logic         clk,
  input  logic         rst_n,
  input  snes_levels_t levels,
  output logic         dead
);

  localparam logic [17:0] LIMIT = 18'(DEAD_TIMEOUT);

  logic [17:0] low_cnt;  // Cycles since CPU clock was last high

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      low_cnt <= '0;
    end else if (levels.cpu_clk) begin
      low_cnt <= '0;
    end else if (low_cnt != '1) begin
      low_cnt <= low_cnt + 18'd1;  // Saturates
    end
  end

  // Console counts as dead out of reset until its clock is seen
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      dead <= 1'b1;
    end else if (levels.cpu_clk) begin
      dead <= 1'b0;
    end else if (low_cnt > LIMIT) begin
      dead <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/mcu_access_fsm.sv ====
`default_nettype none

module mcu_access_fsm
  import snes_bus_pkg::*;
  import rom_bus_pkg::*;
#(
  parameter int unsigned ROM_CYCLE_LEN = 8
) (
  input  logic          clk,
  input  logic          rst_n,
  input  mcu_req_t      req,
  input  snes_strobes_t strobes,
  input  snes_levels_t  levels,
  input  logic          dead,
  input  logic          rom_hit,
  output mcu_grant_t    grant,
  output mcu_req_t      req_latched,
  output logic          rdy
);

  localparam int DW = $clog2(ROM_CYCLE_LEN + 2);

  // One-hot state encoding
  localparam logic [4:0] ST_IDLE    = 5'b00001;
  localparam logic [4:0] ST_RD_ADDR = 5'b00010;
  localparam logic [4:0] ST_RD_END  = 5'b00100;
  localparam logic [4:0] ST_WR_ADDR = 5'b01000;
  localparam logic [4:0] ST_WR_END  = 5'b10000;

  logic [4:0]    state;
  logic [DW-1:0] delay;
  logic          rd_pend;
  logic          wr_pend;
  logic          free_strobe;
  rom_addr_t     addr_q;
  logic [7:0]    wdata_q;

  logic free_slot;
  logic at_end;

  ////////////////////////////////
  // Request capture
  ////////////////////////////////

  assign at_end = |(state & (ST_RD_END | ST_WR_END));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (req.rrq) begin
      rd_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (req.wrq) begin
      wr_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (at_end) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;  // Access done
    end
  end

  always_ff @(posedge clk) begin
    if (req.rrq || req.wrq) addr_q <= req.addr;
    if (req.wrq) wdata_q <= req.wdata;
  end

  assign req_latched.rrq   = rd_pend;
  assign req_latched.wrq   = wr_pend;
  assign req_latched.addr  = addr_q;
  assign req_latched.wdata = wdata_q;

  ////////////////////////////////
  // Free bus slots
  ////////////////////////////////

  // Cycle after cycle_start is free if the console is not reading ROM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= strobes.cycle_start & ~rom_hit;
    end
  end

  assign free_slot = strobes.cycle_end | free_strobe;

  ////////////////////////////////
  // Access sequencer
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      delay <= '0;
    end else if (dead && levels.cpu_clk) begin
      state <= ST_IDLE;  // Console woke up, retry later
    end else begin
      case (state)
        ST_IDLE: begin
          if (free_slot || dead) begin
            if (rd_pend) begin
              state <= ST_RD_ADDR;
              delay <= DW'(ROM_CYCLE_LEN);
            end else if (wr_pend) begin
              state <= ST_WR_ADDR;
              delay <= DW'(ROM_CYCLE_LEN);
            end
          end
        end
        ST_RD_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_RD_END;
        end
        ST_WR_ADDR: begin
          delay <= delay - 1'b1;
          if (delay == '0) state <= ST_WR_END;
        end
        ST_RD_END, ST_WR_END: state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign grant.rd_hit = |(state & ST_RD_ADDR);
  assign grant.wr_hit = |(state & ST_WR_ADDR);

endmodule

`default_nettype wire

// ==== design/rom_port_mux.sv ====
`default_nettype none

module rom_port_mux
  import snes_bus_pkg::*;
  import rom_bus_pkg::*;
#(
  parameter rom_addr_t ROM_MASK = 24'h3FFFFF
) (
  input  logic         clk,
  input  logic         rst_n,
  input  snes_levels_t levels,
  input  mcu_grant_t   grant,
  input  mcu_req_t     req_latched,
  input  rom_word_u    rom_data_in,
  output rom_ctrl_t    rom_ctrl,
  output rom_word_u    rom_data_out,
  output logic         rom_hit,
  output logic [7:0]   snes_data_out,
  output logic         snes_databus_oe_n,
  output logic [7:0]   mcu_rdata
);

  rom_addr_t  mapped_addr;
  rom_addr_t  sel_addr;
  logic       mcu_hit;
  logic [7:0] rd_byte;

  ////////////////////////////////
  // Mapper
  ////////////////////////////////

  assign mapped_addr = rom_addr_t'(levels.addr) & ROM_MASK;
  assign rom_hit     = ~levels.romsel_n;

  ////////////////////////////////
  // Address and lanes
  ////////////////////////////////

  assign mcu_hit  = grant.rd_hit | grant.wr_hit;
  assign sel_addr = mcu_hit ? req_latched.addr : mapped_addr;  // MCU wins while granted

  assign rom_ctrl.addr    = sel_addr[23:1];
  assign rom_ctrl.bhe_n   = sel_addr[0];   // Even byte on the high lane
  assign rom_ctrl.ble_n   = ~sel_addr[0];
  assign rom_ctrl.we_n    = ~grant.wr_hit;
  assign rom_ctrl.data_oe = grant.wr_hit;

  // Write byte on its lane only, other lane parked at zero
  always_comb begin
    rom_data_out.word = '0;
    if (sel_addr[0]) begin
      rom_data_out.bytes.lo = req_latched.wdata;
    end else begin
      rom_data_out.bytes.hi = req_latched.wdata;
    end
  end

  ////////////////////////////////
  // Read data
  ////////////////////////////////

  assign rd_byte = sel_addr[0] ? rom_data_in.bytes.lo : rom_data_in.bytes.hi;

  assign snes_data_out     = rd_byte;
  assign snes_databus_oe_n = ~rom_hit | levels.read_n;  // Drive only on ROM reads

  // Last sample of the hold phase is the one the MCU sees
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mcu_rdata <= '0;
    end else if (grant.rd_hit) begin
      mcu_rdata <= rd_byte;
    end
  end

endmodule

`default_nettype wire

// ==== design/snes_rom_arbiter.sv ====
`default_nettype none

module snes_rom_arbiter
  import snes_bus_pkg::*;
  import rom_bus_pkg::*;
#(
  parameter int unsigned ROM_CYCLE_LEN = 8,
  parameter int unsigned DEAD_TIMEOUT  = 96000,
  parameter logic [23:0] ROM_MASK      = 24'h3FFFFF
) (
  input  logic       CLK2,
  input  logic       rst_n,
  // Console bus
  input  snes_addr_t snes_addr,
  input  logic       snes_read_n,
  input  logic       snes_cpu_clk,
  input  logic       snes_romsel_n,
  output logic [7:0] snes_data_out,
  output logic       snes_databus_oe_n,
  output logic       snes_dead,
  // MCU
  input  mcu_req_t   mcu_req,
  output logic       mcu_rdy,
  output logic [7:0] mcu_rdata,
  // PSRAM
  input  rom_word_u  rom_data_in,
  output rom_ctrl_t  rom_ctrl,
  output rom_word_u  rom_data_out
);

  snes_levels_t  levels;
  snes_strobes_t strobes;
  mcu_grant_t    grant;
  mcu_req_t      req_latched;
  logic          rom_hit;

  snes_bus_sync u_sync (
    .clk           (CLK2),
    .rst_n         (rst_n),
    .snes_addr     (snes_addr),
    .snes_read_n   (snes_read_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_romsel_n (snes_romsel_n),
    .levels        (levels),
    .strobes       (strobes)
  );

  snes_alive_timer #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) u_alive (
    .clk    (CLK2),
    .rst_n  (rst_n),
    .levels (levels),
    .dead   (snes_dead)
  );

  mcu_access_fsm #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) u_fsm (
    .clk         (CLK2),
    .rst_n       (rst_n),
    .req         (mcu_req),
    .strobes     (strobes),
    .levels      (levels),
    .dead        (snes_dead),
    .rom_hit     (rom_hit),
    .grant       (grant),
    .req_latched (req_latched),
    .rdy         (mcu_rdy)
  );

  rom_port_mux #(.ROM_MASK(ROM_MASK)) u_mux (
    .clk               (CLK2),
    .rst_n             (rst_n),
    .levels            (levels),
    .grant             (grant),
    .req_latched       (req_latched),
    .rom_data_in       (rom_data_in),
    .rom_ctrl          (rom_ctrl),
    .rom_data_out      (rom_data_out),
    .rom_hit           (rom_hit),
    .snes_data_out     (snes_data_out),
    .snes_databus_oe_n (snes_databus_oe_n),
    .mcu_rdata         (mcu_rdata)
  );

endmodule

`default_nettype wire

// ==== test/tb_snes_rom_arbiter.sv ====
`default_nettype none

module tb_snes_rom_arbiter
  import snes_bus_pkg::*;
  import rom_bus_pkg::*;
();

  localparam int          ROM_CYCLE_LEN = 8;
  localparam int          DEAD_TIMEOUT  = 300;
  localparam logic [23:0] ROM_MASK      = 24'h00FFFF;

  localparam int PSRAM_WORDS   = 32768;
  localparam int N_DEAD_READS  = 40;
  localparam int N_DEAD_WRITES = 40;
  localparam int N_CON_READS   = 60;
  localparam int N_MIX_MCU     = 24;
  localparam int N_MIX_CON     = 40;
  localparam int RDY_TIMEOUT   = 200;   // Cycles one MCU access may take
  localparam int PHASE         = 24;    // CPU clock half period in CLK2 cycles

  localparam int N_ACCESS = N_DEAD_READS + 2 * N_DEAD_WRITES + N_CON_READS
                            + N_MIX_MCU + N_MIX_CON;
  localparam int WATCHDOG_CYCLES = N_ACCESS * 200 + 4 * DEAD_TIMEOUT;

  logic       CLK2;
  logic       rst_n;
  snes_addr_t snes_addr;
  logic       snes_read_n;
  logic       snes_cpu_clk;
  logic       snes_romsel_n;
  logic [7:0] snes_data_out;
  logic       snes_databus_oe_n;
  logic       snes_dead;
  mcu_req_t   mcu_req;
  logic       mcu_rdy;
  logic [7:0] mcu_rdata;
  rom_word_u  rom_data_in;
  rom_ctrl_t  rom_ctrl;
  rom_word_u  rom_data_out;

  logic [15:0] psram   [PSRAM_WORDS];  // What the DUT sees
  logic [15:0] ref_mem [PSRAM_WORDS];  // Expected contents

  int checks;
  int errors;
  int test_errors;
  bit mix_done;

  snes_rom_arbiter #(
    .ROM_CYCLE_LEN (ROM_CYCLE_LEN),
    .DEAD_TIMEOUT  (DEAD_TIMEOUT),
    .ROM_MASK      (ROM_MASK)
  ) uut (
    .CLK2              (CLK2),
    .rst_n             (rst_n),
    .snes_addr         (snes_addr),
    .snes_read_n       (snes_read_n),
    .snes_cpu_clk      (snes_cpu_clk),
    .snes_romsel_n     (snes_romsel_n),
    .snes_data_out     (snes_data_out),
    .snes_databus_oe_n (snes_databus_oe_n),
    .snes_dead         (snes_dead),
    .mcu_req           (mcu_req),
    .mcu_rdy           (mcu_rdy),
    .mcu_rdata         (mcu_rdata),
    .rom_data_in       (rom_data_in),
    .rom_ctrl          (rom_ctrl),
    .rom_data_out      (rom_data_out)
  );

  always #10 CLK2 = ~CLK2;

  //////////////////////////////
  // PSRAM model
  //////////////////////////////

  // Only the 64 KB image is backed, words above it read back inverted
  assign rom_data_in.word = (rom_ctrl.addr[22:15] == '0) ? psram[rom_ctrl.addr[14:0]]
                                                          : ~psram[rom_ctrl.addr[14:0]];

  always @(posedge CLK2) begin
    if (!rom_ctrl.we_n && rom_ctrl.data_oe && rom_ctrl.addr[22:15] == '0) begin
      if (!rom_ctrl.bhe_n) psram[rom_ctrl.addr[14:0]][15:8] <= rom_data_out.bytes.hi;
      if (!rom_ctrl.ble_n) psram[rom_ctrl.addr[14:0]][7:0] <= rom_data_out.bytes.lo;
    end
  end

  // Odd byte address on the low lane, even on the high lane
  function automatic logic [7:0] model_byte(input logic [23:0] a);
    logic [15:0] w;
    w = ref_mem[a[15:1]];
    return a[0] ? w[7:0] : w[15:8];
  endfunction

  task automatic model_write(input logic [23:0] a, input logic [7:0] d);
    if (a[0]) ref_mem[a[15:1]][7:0] = d;
    else ref_mem[a[15:1]][15:8] = d;
  endtask

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input rom_word_u got, input rom_word_u exp);
    checks++;
    if (got.word !== exp.word) begin
      $display("Mismatch %s: got %h, expected %h", name, got.word, exp.word);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    $display("Test %s finished with %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  //////////////////////////////
  // MCU side
  //////////////////////////////

  task automatic wait_rdy();
    int n;
    n = 0;
    while (!mcu_rdy && n < RDY_TIMEOUT) begin
      @(negedge CLK2);
      n++;
    end
    if (!mcu_rdy) begin
      $display("MCU access did not finish within %0d cycles", RDY_TIMEOUT);
      errors++;
    end
  endtask

  task automatic mcu_read(input logic [23:0] a);
    logic [7:0] exp;
    exp = model_byte(a);
    mcu_req.rrq  = 1'b1;
    mcu_req.addr = a;
    @(negedge CLK2);
    mcu_req.rrq = 1'b0;
    check_bit("mcu_rdy", mcu_rdy, 1'b0);  // Must drop right after the pulse
    wait_rdy();
    check_byte("mcu_rdata", mcu_rdata, exp);
  endtask

  task automatic mcu_write(input logic [23:0] a, input logic [7:0] d);
    mcu_req.wrq   = 1'b1;
    mcu_req.addr  = a;
    mcu_req.wdata = d;
    @(negedge CLK2);
    mcu_req.wrq = 1'b0;
    check_bit("mcu_rdy", mcu_rdy, 1'b0);
    wait_rdy();
    model_write(a, d);
    check_word("psram word", psram[a[15:1]], ref_mem[a[15:1]]);
  endtask

  // Writes stay in the upper half, console reads in the lower half
  task automatic mcu_mix(input int n);
    logic [23:0] a;
    for (int i = 0; i < n; i++) begin
      repeat ($urandom % 8) @(negedge CLK2);
      a = 24'($urandom) & ROM_MASK;
      if ($urandom % 2 == 0) mcu_read(a);
      else mcu_write(a | 24'h008000, 8'($urandom));
    end
  endtask

  //////////////////////////////
  // Console side
  //////////////////////////////

  // One read per CPU clock period, keeps going until the MCU mix is done
  task automatic console_reads(input int n);
    logic [23:0] a;
    for (int i = 0; i < n || !mix_done; i++) begin
      a = 24'($urandom) & 24'hFF7FFF;
      snes_addr     = a;
      snes_cpu_clk  = 1'b1;
      snes_read_n   = 1'b0;
      snes_romsel_n = 1'b0;
      repeat (PHASE - 3) @(negedge CLK2);
      check_bit("snes_databus_oe_n", snes_databus_oe_n, 1'b0);
      check_byte("snes_data_out", snes_data_out, model_byte(a & ROM_MASK));
      repeat (3) @(negedge CLK2);
      snes_cpu_clk  = 1'b0;
      snes_read_n   = 1'b1;
      snes_romsel_n = 1'b1;
      repeat (PHASE) @(negedge CLK2);
    end
  endtask

  task automatic wait_dead_low(input int limit);
    int n;
    n = 0;
    while (snes_dead && n < limit) begin
      @(negedge CLK2);
      n++;
    end
    if (snes_dead) begin
      $display("snes_dead still high %0d cycles after the CPU clock started", limit);
      errors++;
    end
  endtask

  task automatic dead_detect();
    int n;
    snes_cpu_clk = 1'b1;
    repeat (PHASE) @(negedge CLK2);
    snes_cpu_clk = 1'b0;  // Clock stops here
    for (n = 1; n <= DEAD_TIMEOUT; n++) begin
      @(negedge CLK2);
      if (snes_dead) begin
        $display("snes_dead rose only %0d cycles after the CPU clock stopped", n);
        errors++;
        break;
      end
    end
    n = 0;
    while (!snes_dead && n < 10) begin
      @(negedge CLK2);
      n++;
    end
    if (!snes_dead) begin
      $display("snes_dead still low %0d cycles after the CPU clock stopped", DEAD_TIMEOUT + 10);
      errors++;
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [23:0] a;
    logic [15:0] w;
    CLK2          = 1'b0;
    rst_n         = 1'b0;
    snes_addr     = '0;
    snes_read_n   = 1'b1;
    snes_cpu_clk  = 1'b0;
    snes_romsel_n = 1'b1;
    mcu_req       = '0;
    checks        = 0;
    errors        = 0;
    test_errors   = 0;
    mix_done      = 1'b1;
    void'($urandom(85));
    for (int i = 0; i < PSRAM_WORDS; i++) begin
      w = 16'($urandom);
      psram[i]  <= w;
      ref_mem[i] = w;
    end
    repeat (2) @(negedge CLK2);
    rst_n = 1'b1;

    check_bit("mcu_rdy", mcu_rdy, 1'b1);
    check_bit("rom_ctrl.we_n", rom_ctrl.we_n, 1'b1);
    check_bit("rom_ctrl.data_oe", rom_ctrl.data_oe, 1'b0);
    check_bit("snes_databus_oe_n", snes_databus_oe_n, 1'b1);
    check_bit("snes_dead", snes_dead, 1'b1);
    end_test("reset state");

    for (int i = 0; i < N_DEAD_READS; i++) begin
      mcu_read(24'($urandom) & ROM_MASK);
    end
    end_test("MCU reads while dead");

    for (int i = 0; i < N_DEAD_WRITES; i++) begin
      a = 24'($urandom) & ROM_MASK;
      mcu_write(a, 8'($urandom));
      mcu_read(a);
    end
    end_test("MCU writes while dead");

    fork
      console_reads(N_CON_READS);
      wait_dead_low(10);
    join
    end_test("console reads ROM");

    mix_done = 1'b0;
    fork
      begin
        mcu_mix(N_MIX_MCU);
        mix_done = 1'b1;
      end
      console_reads(N_MIX_CON);
    join
    end_test("MCU and console mixed");

    dead_detect();
    end_test("dead detection");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Budget grows with the number of bus accesses
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK2);
    $display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
design/snes_bus_pkg.sv
design/rom_bus_pkg.sv
design/snes_bus_sync.sv
design/snes_alive_timer.sv
design/mcu_access_fsm.sv
design/rom_port_mux.sv
design/snes_rom_arbiter.sv
test/tb_snes_rom_arbiter.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_snes_rom_arbiter
FILELIST   = list.f
OBJDIR     = obj_dir
PASS_MSG   = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
